/* src/mvm_pkg.sv */
`default_nettype none

package mvm_pkg;

    // --------------------------------------------------
    // widths
    // --------------------------------------------------
    localparam int DATA_W     = 32;  // data and accumulator word.
    localparam int MAT_ADDR_W = 7;   // weight / column address.
    localparam int VLEN_W     = 8;   // holds 1 to 128.
    localparam int RES_IDX_W  = 3;   // result row index.
    localparam int ADR_W      = 16;  // wishbone byte address.
    localparam int SEL_W      = DATA_W / 8;
    localparam int CORE_W     = 4;   // core select, up to 16 cores.

    // --------------------------------------------------
    // byte address map
    // --------------------------------------------------
    localparam logic [ADR_W-1:0] ADR_CTRL        = 16'h0000;  // bit 0 start.
    localparam logic [ADR_W-1:0] ADR_STATUS      = 16'h0004;  // bit 0 busy, bit 1 done.
    localparam logic [ADR_W-1:0] ADR_VLEN        = 16'h0008;
    localparam logic [ADR_W-1:0] ADR_RESULT_BASE = 16'h0100;  // one word per row.
    localparam logic [ADR_W-1:0] ADR_VEC_BASE    = 16'h0200;  // one word per element.
    localparam logic [ADR_W-1:0] ADR_MAT_BASE    = 16'h1000;
    localparam logic [ADR_W-1:0] MAT_CORE_STRIDE = 16'h0200;  // one row per core.

    // weight pair write, odd column in the high half
    typedef struct packed {
        logic                    valid;
        logic [CORE_W-1:0]       core;
        logic [MAT_ADDR_W-1:0]   addr;  // even column.
        logic [2*DATA_W-1:0]     data;
    } mat_wr_t;

    // broadcast from the sequencer to every core
    typedef struct packed {
        logic                    init;
        logic                    exec;
        logic [MAT_ADDR_W-1:0]   mat_addr;
        logic                    update;
        logic                    out_period;
    } exec_ctl_t;

    // wishbone classic request, host side
    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [ADR_W-1:0]        adr;
        logic [DATA_W-1:0]       dat_w;
        logic [SEL_W-1:0]        sel;
    } wb_req_t;

endpackage

`default_nettype wire

/* src/mvm_core.sv */
`timescale 1ns/10ps
`default_nettype none

module mvm_core #(
    parameter int CORE_ID   = 0,
    parameter int MAT_DEPTH = 128
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  mvm_pkg::mat_wr_t             mat_wr,
    input  mvm_pkg::exec_ctl_t           ctl,
    input  logic [mvm_pkg::DATA_W-1:0]   src_data,
    input  logic [mvm_pkg::DATA_W-1:0]   acc_next,
    output logic [mvm_pkg::DATA_W-1:0]   acc
);

    import mvm_pkg::*;

    localparam int AW = $clog2(MAT_DEPTH);

    // row is split into even and odd banks so a pair lands in one cycle
    logic [DATA_W-1:0] mem_even [MAT_DEPTH/2];
    logic [DATA_W-1:0] mem_odd  [MAT_DEPTH/2];

    logic              wr_hit;
    logic [DATA_W-1:0] w_q;        // fetched weight, t+1.
    logic [DATA_W-1:0] m_q;        // weight operand, t+2.
    logic [DATA_W-1:0] d_q;        // vector operand, t+2.
    logic              init_d1, init_d2;
    logic              exec_d1, exec_d2;
    logic [DATA_W-1:0] acc_sum;
    logic [DATA_W-1:0] acc_shift;

    assign wr_hit = mat_wr.valid && (mat_wr.core == CORE_W'(CORE_ID));

    // --------------------------------------------------
    // weight memory and operand stage
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_hit) begin
            mem_even[mat_wr.addr[AW-1:1]] <= mat_wr.data[DATA_W-1:0];
            mem_odd[mat_wr.addr[AW-1:1]]  <= mat_wr.data[2*DATA_W-1:DATA_W];
        end
        if (ctl.exec) begin
            w_q <= ctl.mat_addr[0] ? mem_odd[ctl.mat_addr[AW-1:1]]
                                   : mem_even[ctl.mat_addr[AW-1:1]];
        end
        if (exec_d1) begin
            m_q <= w_q;
            d_q <= src_data;  // vector buffer answers at t+1 too.
        end
    end

    // --------------------------------------------------
    // accumulate and shift-out
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            init_d1   <= 1'b0;
            init_d2   <= 1'b0;
            exec_d1   <= 1'b0;
            exec_d2   <= 1'b0;
            acc_sum   <= '0;
            acc_shift <= '0;
        end else begin
            init_d1 <= ctl.init;
            init_d2 <= init_d1;
            exec_d1 <= ctl.exec;
            exec_d2 <= exec_d1;
            // init lines up with column 0, so clear and add in one step.
            if (init_d2 || exec_d2) begin
                acc_sum <= (init_d2 ? '0 : acc_sum) + (exec_d2 ? m_q * d_q : '0);
            end
            if (ctl.out_period) begin
                acc_shift <= acc_next;
            end
        end
    end

    assign acc = ctl.update ? acc_sum : acc_shift;  // sum on update, chain after.

endmodule

`default_nettype wire

/* src/vector_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module vector_buffer #(
    parameter int MAT_DEPTH = 128
) (
    input  wire                              clk,
    input  logic                             wr_en,
    input  logic [mvm_pkg::MAT_ADDR_W-1:0]   wr_addr,
    input  logic [mvm_pkg::DATA_W-1:0]       wr_data,
    input  mvm_pkg::exec_ctl_t               ctl,
    output logic [mvm_pkg::DATA_W-1:0]       src_data
);

    import mvm_pkg::*;

    localparam int AW = $clog2(MAT_DEPTH);

    logic [DATA_W-1:0] mem [MAT_DEPTH];

    // --------------------------------------------------
    // host write port
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr[AW-1:0]] <= wr_data;
        end
    end

    // --------------------------------------------------
    // sequencer read port
    // --------------------------------------------------
    // one cycle latency, same as the weight fetch in each core
    always_ff @(posedge clk) begin
        if (ctl.exec) begin
            src_data <= mem[ctl.mat_addr[AW-1:0]];
        end
    end

endmodule

`default_nettype wire

/* src/mvm_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module mvm_sequencer #(
    parameter int NUM_CORES = 8
) (
    input  wire                           clk,
    input  wire                           arst_n,
    input  logic                          start,
    input  logic [mvm_pkg::VLEN_W-1:0]    vlen,
    output mvm_pkg::exec_ctl_t            ctl,
    output logic                          busy,
    output logic                          done
);

    import mvm_pkg::*;

    // holds both the drain length and NUM_CORES-1
    localparam int CNT_W = (NUM_CORES > 2) ? $clog2(NUM_CORES) : 1;

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_DRAIN,
        S_SHIFT
    } state_t;

    state_t            state;
    logic [VLEN_W-1:0] col;       // current column.
    logic [VLEN_W-1:0] vlen_q;
    logic [CNT_W-1:0]  cnt;       // drain / shift cycles.
    logic              init_q;
    logic              exec_q;
    logic              update_q;
    logic              out_q;
    logic              done_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            col      <= '0;
            vlen_q   <= '0;
            cnt      <= '0;
            init_q   <= 1'b0;
            exec_q   <= 1'b0;
            update_q <= 1'b0;
            out_q    <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            init_q   <= 1'b0;
            update_q <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state  <= S_RUN;
                        init_q <= 1'b1;
                        exec_q <= 1'b1;  // column 0 goes out with init.
                        col    <= '0;
                        vlen_q <= vlen;
                        done_q <= 1'b0;
                    end
                end
                S_RUN: begin
                    // a length of zero runs as one.
                    if (col + 1'b1 >= vlen_q) begin
                        exec_q <= 1'b0;
                        cnt    <= '0;
                        state  <= S_DRAIN;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                S_DRAIN: begin
                    // two idle cycles, the last product lands in the third.
                    if (cnt == CNT_W'(1)) begin
                        update_q <= 1'b1;
                        out_q    <= 1'b1;
                        cnt      <= '0;
                        state    <= S_SHIFT;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                S_SHIFT: begin
                    if (cnt == CNT_W'(NUM_CORES - 1)) begin
                        out_q  <= 1'b0;
                        done_q <= 1'b1;
                        state  <= S_IDLE;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    assign ctl.init       = init_q;
    assign ctl.exec       = exec_q;
    assign ctl.mat_addr   = col[MAT_ADDR_W-1:0];
    assign ctl.update     = update_q;
    assign ctl.out_period = out_q;

    assign busy = (state != S_IDLE);
    assign done = done_q;

endmodule

`default_nettype wire

/* src/result_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module result_buffer #(
    parameter int NUM_CORES = 8
) (
    input  wire                             clk,
    input  wire                             arst_n,
    input  mvm_pkg::exec_ctl_t              ctl,
    input  logic [mvm_pkg::DATA_W-1:0]      acc0,
    input  logic [mvm_pkg::RES_IDX_W-1:0]   rd_idx,
    output logic [mvm_pkg::DATA_W-1:0]      rd_data
);

    import mvm_pkg::*;

    localparam int IDX_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

    logic [DATA_W-1:0] res [NUM_CORES];
    logic [IDX_W-1:0]  cnt;
    logic [IDX_W-1:0]  wr_idx;

    assign wr_idx = ctl.update ? '0 : cnt;  // row 0 arrives on update.

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cnt <= '0;
            for (int i = 0; i < NUM_CORES; i++) begin
                res[i] <= '0;
            end
        end else if (ctl.out_period) begin
            res[wr_idx] <= acc0;
            cnt         <= wr_idx + 1'b1;
        end
    end

    // rows past the core count read as zero
    assign rd_data = (int'(rd_idx) < NUM_CORES) ? res[IDX_W'(rd_idx)] : '0;

endmodule

`default_nettype wire

/* src/mvm_wb_slave.sv */
`timescale 1ns/10ps
`default_nettype none

module mvm_wb_slave #(
    parameter int NUM_CORES = 8
) (
    input  wire                              clk,
    input  wire                              arst_n,
    input  mvm_pkg::wb_req_t                 wb,
    output logic [mvm_pkg::DATA_W-1:0]       wb_dat_r,
    output logic                             wb_ack,
    input  logic                             busy,
    input  logic                             done,
    input  logic [mvm_pkg::DATA_W-1:0]       res_data,
    output logic [mvm_pkg::RES_IDX_W-1:0]    res_idx,
    output logic                             start,
    output logic [mvm_pkg::VLEN_W-1:0]       vlen,
    output logic                             vec_wr_en,
    output logic [mvm_pkg::MAT_ADDR_W-1:0]   vec_wr_addr,
    output logic [mvm_pkg::DATA_W-1:0]       vec_wr_data,
    output mvm_pkg::mat_wr_t                 mat_wr
);

    import mvm_pkg::*;

    localparam int STRIDE_SH = $clog2(MAT_CORE_STRIDE);

    logic                  wb_hit;
    logic                  wb_write;
    logic                  is_ctrl, is_status, is_vlen, is_res, is_vec, is_mat;
    logic [ADR_W-1:0]      mat_off;
    logic [ADR_W-1:0]      mat_core;
    logic [MAT_ADDR_W-1:0] mat_col;
    logic [DATA_W-1:0]     even_q;   // even column waiting for its pair.
    logic                  mat_valid_q;
    logic [CORE_W-1:0]     mat_core_q;
    logic [MAT_ADDR_W-1:0] mat_addr_q;
    logic [2*DATA_W-1:0]   mat_data_q;
    logic [DATA_W-1:0]     rd_mux;

    // --------------------------------------------------
    // decode
    // --------------------------------------------------
    assign wb_hit   = wb.cyc && wb.stb && !wb_ack;  // one ack per access.
    assign wb_write = wb_hit && wb.we && (&wb.sel);  // full words only.

    assign is_ctrl   = (wb.adr == ADR_CTRL);
    assign is_status = (wb.adr == ADR_STATUS);
    assign is_vlen   = (wb.adr == ADR_VLEN);
    assign is_res    = (wb.adr[ADR_W-1:5] == ADR_RESULT_BASE[ADR_W-1:5]);
    assign is_vec    = (wb.adr[ADR_W-1:9] == ADR_VEC_BASE[ADR_W-1:9]);

    assign mat_off  = wb.adr - ADR_MAT_BASE;
    assign mat_core = mat_off >> STRIDE_SH;
    assign mat_col  = mat_off[2 +: MAT_ADDR_W];
    assign is_mat   = (wb.adr >= ADR_MAT_BASE) && (int'(mat_core) < NUM_CORES);

    assign res_idx = wb.adr[2 +: RES_IDX_W];

    assign start       = wb_write && is_ctrl && wb.dat_w[0] && !busy;
    assign vec_wr_en   = wb_write && is_vec && !busy;
    assign vec_wr_addr = wb.adr[2 +: MAT_ADDR_W];
    assign vec_wr_data = wb.dat_w;

    // --------------------------------------------------
    // control registers
    // --------------------------------------------------
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wb_ack      <= 1'b0;
            vlen        <= VLEN_W'(1);
            mat_valid_q <= 1'b0;
        end else begin
            wb_ack      <= wb_hit;
            mat_valid_q <= wb_write && is_mat && mat_col[0] && !busy;  // odd half.
            if (wb_write && is_vlen) begin
                vlen <= wb.dat_w[VLEN_W-1:0];
            end
        end
    end

    // --------------------------------------------------
    // weight pairing and readback
    // --------------------------------------------------
    always_ff @(posedge clk) begin
        if (wb_write && is_mat && !mat_col[0]) begin
            even_q <= wb.dat_w;
        end
        if (wb_write && is_mat && mat_col[0]) begin
            mat_core_q <= mat_core[CORE_W-1:0];
            mat_addr_q <= {mat_col[MAT_ADDR_W-1:1], 1'b0};
            mat_data_q <= {wb.dat_w, even_q};
        end
        if (wb_hit) begin
            wb_dat_r <= rd_mux;
        end
    end

    always_comb begin
        rd_mux = '0;  // ctrl and memories read as zero.
        if (is_status) begin
            rd_mux = {{(DATA_W-2){1'b0}}, done, busy};
        end else if (is_vlen) begin
            rd_mux = {{(DATA_W-VLEN_W){1'b0}}, vlen};
        end else if (is_res) begin
            rd_mux = res_data;
        end
    end

    assign mat_wr.valid = mat_valid_q;
    assign mat_wr.core  = mat_core_q;
    assign mat_wr.addr  = mat_addr_q;
    assign mat_wr.data  = mat_data_q;

endmodule

`default_nettype wire

/* src/mvm_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mvm_top #(
    parameter int NUM_CORES = 8,
    parameter int MAT_DEPTH = 128
) (
    input  wire                          clk,
    input  wire                          arst_n,
    input  mvm_pkg::wb_req_t             wb,
    output logic [mvm_pkg::DATA_W-1:0]   wb_dat_r,
    output logic                         wb_ack
);

    import mvm_pkg::*;

    mat_wr_t               mat_wr;
    exec_ctl_t             ctl;
    logic                  start;
    logic                  busy;
    logic                  done;
    logic [VLEN_W-1:0]     vlen;
    logic                  vec_wr_en;
    logic [MAT_ADDR_W-1:0] vec_wr_addr;
    logic [DATA_W-1:0]     vec_wr_data;
    logic [DATA_W-1:0]     src_data;
    logic [DATA_W-1:0]     res_data;
    logic [RES_IDX_W-1:0]  res_idx;
    logic [DATA_W-1:0]     acc_chain [NUM_CORES+1];  // core i reads entry i+1.

    // --------------------------------------------------
    // host side
    // --------------------------------------------------
    mvm_wb_slave #(.NUM_CORES(NUM_CORES)) u_wb_slave (
        .clk        (clk),
        .arst_n     (arst_n),
        .wb         (wb),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .busy       (busy),
        .done       (done),
        .res_data   (res_data),
        .res_idx    (res_idx),
        .start      (start),
        .vlen       (vlen),
        .vec_wr_en  (vec_wr_en),
        .vec_wr_addr(vec_wr_addr),
        .vec_wr_data(vec_wr_data),
        .mat_wr     (mat_wr)
    );

    mvm_sequencer #(.NUM_CORES(NUM_CORES)) u_sequencer (
        .clk   (clk),
        .arst_n(arst_n),
        .start (start),
        .vlen  (vlen),
        .ctl   (ctl),
        .busy  (busy),
        .done  (done)
    );

    vector_buffer #(.MAT_DEPTH(MAT_DEPTH)) u_vector_buffer (
        .clk     (clk),
        .wr_en   (vec_wr_en),
        .wr_addr (vec_wr_addr),
        .wr_data (vec_wr_data),
        .ctl     (ctl),
        .src_data(src_data)
    );

    result_buffer #(.NUM_CORES(NUM_CORES)) u_result_buffer (
        .clk    (clk),
        .arst_n (arst_n),
        .ctl    (ctl),
        .acc0   (acc_chain[0]),
        .rd_idx (res_idx),
        .rd_data(res_data)
    );

    // --------------------------------------------------
    // core array
    // --------------------------------------------------
    assign acc_chain[NUM_CORES] = '0;  // end of the chain.

    for (genvar i = 0; i < NUM_CORES; i++) begin : g_core
        mvm_core #(
            .CORE_ID  (i),
            .MAT_DEPTH(MAT_DEPTH)
        ) u_core (
            .clk     (clk),
            .arst_n  (arst_n),
            .mat_wr  (mat_wr),
            .ctl     (ctl),
            .src_data(src_data),
            .acc_next(acc_chain[i+1]),
            .acc     (acc_chain[i])
        );
    end

endmodule

`default_nettype wire

/* testbench/mvm_tb.sv */
`timescale 1ns/10ps
`default_nettype none

module mvm_tb;

    import mvm_pkg::*;

    localparam int NUM_CORES    = 8;
    localparam int MAT_DEPTH    = 128;
    localparam int CLK_HALF     = 5;
    localparam int ACK_LIMIT    = 16;
    localparam int NUM_RUNS     = 5;
    localparam int NUM_ACCESSES = 2 * NUM_CORES * MAT_DEPTH + 3 * MAT_DEPTH + 8 * NUM_CORES + 32;
    localparam int WATCHDOG_CYCLES = (NUM_RUNS * (MAT_DEPTH + 12) + 3 * NUM_ACCESSES) * 2;

    logic              clk;
    logic              arst_n;
    wb_req_t           wb;
    logic [DATA_W-1:0] wb_dat_r;
    logic              wb_ack;

    logic [DATA_W-1:0] weights [NUM_CORES][MAT_DEPTH];  // host copy of the matrix.
    logic [DATA_W-1:0] vec [MAT_DEPTH];
    integer            seed;
    int                errors = 0;
    int                checks = 0;
    int                access_count = 0;
    int                ack_count = 0;

    mvm_top #(
        .NUM_CORES(NUM_CORES),
        .MAT_DEPTH(MAT_DEPTH)
    ) dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .wb      (wb),
        .wb_dat_r(wb_dat_r),
        .wb_ack  (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #CLK_HALF clk = ~clk;
    end

    always @(posedge clk) begin
        if (wb_ack) begin
            ack_count <= ack_count + 1;  // one per acked cycle.
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    // --------------------------------------------------
    // reference model and checking
    // --------------------------------------------------
    function automatic logic [DATA_W-1:0] ref_row(input int row, input int vlen);
        logic [DATA_W-1:0] sum;
        sum = '0;
        for (int k = 0; k < vlen; k++) begin
            sum = sum + weights[row][k] * vec[k];  // wraps at 32 bits.
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                               input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected %08h, actual %08h", name, expected, actual);
        end
    endtask

    function automatic logic [ADR_W-1:0] weight_addr(input int core, input int col);
        return ADR_MAT_BASE + ADR_W'(core) * MAT_CORE_STRIDE + ADR_W'(col * 4);
    endfunction

    function automatic logic [ADR_W-1:0] vec_addr(input int idx);
        return ADR_VEC_BASE + ADR_W'(idx * 4);
    endfunction

    function automatic logic [ADR_W-1:0] result_addr(input int row);
        return ADR_RESULT_BASE + ADR_W'(row * 4);
    endfunction

    // --------------------------------------------------
    // wishbone classic host
    // --------------------------------------------------
    task automatic wb_access(input logic we, input logic [ADR_W-1:0] adr,
                             input logic [DATA_W-1:0] wdata, output logic [DATA_W-1:0] rdata);
        int wait_cycles;
        wait_cycles = 0;
        rdata = '0;
        @(posedge clk);
        #1;
        wb.cyc   = 1'b1;
        wb.stb   = 1'b1;
        wb.we    = we;
        wb.adr   = adr;
        wb.dat_w = wdata;
        wb.sel   = '1;
        access_count++;
        do begin
            @(posedge clk);
            #1;
            wait_cycles++;
        end while (!wb_ack && wait_cycles < ACK_LIMIT);
        if (wb_ack) begin
            rdata = wb_dat_r;
            check_value("ack latency", 32'd1, DATA_W'(wait_cycles));
        end else begin
            errors++;
            $display("bus access to %04h was never acknowledged", adr);
        end
        wb.cyc = 1'b0;
        wb.stb = 1'b0;
        wb.we  = 1'b0;
    endtask

    task automatic wb_write(input logic [ADR_W-1:0] adr, input logic [DATA_W-1:0] data);
        logic [DATA_W-1:0] unused;
        wb_access(1'b1, adr, data, unused);
    endtask

    task automatic wb_read(input logic [ADR_W-1:0] adr, output logic [DATA_W-1:0] data);
        wb_access(1'b0, adr, '0, data);
    endtask

    // --------------------------------------------------
    // engine helpers
    // --------------------------------------------------
    task automatic load_weights();
        for (int r = 0; r < NUM_CORES; r++) begin
            for (int k = 0; k < MAT_DEPTH; k++) begin
                wb_write(weight_addr(r, k), weights[r][k]);  // even column goes first.
            end
        end
    endtask

    task automatic load_vector();
        for (int k = 0; k < MAT_DEPTH; k++) begin
            wb_write(vec_addr(k), vec[k]);
        end
    endtask

    task automatic start_engine(input int vlen);
        wb_write(ADR_VLEN, DATA_W'(vlen));
        wb_write(ADR_CTRL, 32'h1);
    endtask

    task automatic wait_done(input string name, input int vlen);
        logic [DATA_W-1:0] status;
        int polls;
        polls = 0;
        status = '0;
        while (!status[1] && polls < vlen + NUM_CORES + 16) begin
            wb_read(ADR_STATUS, status);
            polls++;
        end
        if (!status[1]) begin
            errors++;
            $display("%s: done bit not seen after %0d status reads", name, polls);
        end
    endtask

    task automatic check_results(input string name, input int vlen);
        logic [DATA_W-1:0] rdata;
        for (int r = 0; r < NUM_CORES; r++) begin
            wb_read(result_addr(r), rdata);
            check_value($sformatf("%s row %0d", name, r), ref_row(r, vlen), rdata);
        end
    endtask

    // --------------------------------------------------
    // test sequence
    // --------------------------------------------------
    initial begin
        logic [DATA_W-1:0] rdata;
        seed   = 32'hb8ef67e2;
        arst_n = 1'b0;
        wb     = '0;
        repeat (4) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // reset state
        wb_read(ADR_STATUS, rdata);
        check_value("reset status", 32'h0, rdata);
        for (int r = 0; r < NUM_CORES; r++) begin
            wb_read(result_addr(r), rdata);
            check_value($sformatf("reset result row %0d", r), 32'h0, rdata);
        end
        repeat (2) @(posedge clk);
        check_value("reset ack count", DATA_W'(access_count), DATA_W'(ack_count));

        // full length with random operands
        for (int r = 0; r < NUM_CORES; r++) begin
            for (int k = 0; k < MAT_DEPTH; k++) begin
                weights[r][k] = $random(seed);
            end
        end
        for (int k = 0; k < MAT_DEPTH; k++) begin
            vec[k] = $random(seed);
        end
        load_weights();
        load_vector();
        start_engine(MAT_DEPTH);
        wait_done("full run", MAT_DEPTH);
        check_results("full run", MAT_DEPTH);
        wb_read(ADR_STATUS, rdata);
        check_value("full run status", 32'h2, rdata);

        // short vector, same weights
        start_engine(5);
        wait_done("short run", 5);
        check_results("short run", 5);

        // new vector only, weights kept
        for (int k = 0; k < MAT_DEPTH; k++) begin
            vec[k] = $random(seed);
        end
        load_vector();
        start_engine(MAT_DEPTH);
        wait_done("vector reload", MAT_DEPTH);
        check_results("vector reload", MAT_DEPTH);

        // all ones, plus writes while busy
        for (int r = 0; r < NUM_CORES; r++) begin
            for (int k = 0; k < MAT_DEPTH; k++) begin
                weights[r][k] = 32'hffff_ffff;
            end
        end
        for (int k = 0; k < MAT_DEPTH; k++) begin
            vec[k] = 32'hffff_ffff;
        end
        load_weights();
        load_vector();
        start_engine(MAT_DEPTH);
        wb_read(ADR_STATUS, rdata);
        check_value("large operands busy status", 32'h1, rdata);
        wb_write(vec_addr(MAT_DEPTH - 1), 32'h0);  // would land before column 127.
        wb_write(ADR_VLEN, 32'd5);  // only a restart would use it.
        wb_write(ADR_CTRL, 32'h1);
        wb_write(vec_addr(0), 32'h0);
        wait_done("large operands", MAT_DEPTH);
        check_results("large operands", MAT_DEPTH);
        wb_read(ADR_STATUS, rdata);
        check_value("large operands status", 32'h2, rdata);
        start_engine(MAT_DEPTH);
        wait_done("large operands rerun", MAT_DEPTH);
        check_results("large operands rerun", MAT_DEPTH);

        repeat (2) @(posedge clk);
        check_value("final ack count", DATA_W'(access_count), DATA_W'(ack_count));
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/mvm_pkg.sv
src/mvm_core.sv
src/vector_buffer.sv
src/mvm_sequencer.sv
src/result_buffer.sv
src/mvm_wb_slave.sv
src/mvm_top.sv
testbench/mvm_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the matrix-vector engine testbench with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f src.f --top-module mvm_tb -Mdir "$BUILD_DIR" -o mvm_tb_sim

"./$BUILD_DIR/mvm_tb_sim" | tee "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    echo "simulation reported errors, see $LOG"
    exit 1
fi
echo "simulation clean, see $LOG"
